// ==== design/csr_map_pkg.sv ====
`default_nettype none

package csr_map_pkg;

    typedef logic [13:0] csr_addr_t;

    // csr numbers
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    // da set, plv 0, ie off
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;
    localparam logic [31:0] CRMD_MASK  = 32'h0000_01ff;
    localparam logic [31:0] PRMD_MASK  = 32'h0000_0007;
    localparam logic [31:0] LIE_MASK   = 32'h0000_1bff;

    localparam int CRMD_IE_BIT  = 2;
    localparam int IS_SW_W      = 2;
    localparam int IS_HW_W      = 8;
    localparam int TI_BIT       = 11;
    localparam int EENTRY_ALIGN = 6;

endpackage

`default_nettype wire

// ==== design/csr_op_pkg.sv ====
`default_nettype none

package csr_op_pkg;

    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_CSRRD   = 3'd1,
        OP_CSRWR   = 3'd2,
        OP_CSRXCHG = 3'd3,
        OP_ERTN    = 3'd4,
        OP_EXCP    = 3'd5
    } csr_op_e;

    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    localparam ecode_t ECODE_INT = 6'h00;
    localparam ecode_t ECODE_ADE = 6'h08;
    localparam ecode_t ECODE_ALE = 6'h09;
    localparam ecode_t ECODE_SYS = 6'h0b;
    localparam ecode_t ECODE_BRK = 6'h0c;

    // fetch address error
    localparam esubcode_t ESUB_ADEF = 9'h000;

    // csr number for access ops, code pair for exceptions
    typedef union packed {
        struct packed {
            logic [1:0]            pad;
            csr_map_pkg::csr_addr_t num;
        } csr;
        struct packed {
            logic      pad;
            esubcode_t esub;
            ecode_t    ecode;
        } excp;
    } csr_arg_u;

endpackage

`default_nettype wire

// ==== design/csr_timer.sv ====
`default_nettype none

module csr_timer (
    input  logic        clk,
    input  logic        rstn,
    input  logic        tcfg_we,
    input  logic        ticlr_we,
    input  logic [31:0] wr_data,
    output logic [31:0] tcfg,
    output logic [31:0] tval,
    output logic        ti
);

    logic        tmr_en;
    logic        periodic;
    logic        at_zero;
    logic [31:0] init_val;

    assign tmr_en   = tcfg[0];
    assign periodic = tcfg[1];
    assign at_zero  = (tval == '0);
    assign init_val = {tcfg[31:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            ti   <= 1'b0;
        end
        else
        begin
            if (tcfg_we)
            begin
                tcfg <= wr_data;
                tval <= wr_data[0] ? {wr_data[31:2], 2'b00} : '0;
            end
            else if (tmr_en)
            begin
                if (at_zero)
                    tval <= periodic ? init_val : 32'hffff_ffff;
                else if (tval != 32'hffff_ffff)
                    tval <= tval - 32'd1;
            end

            // clear wins over a new expiry
            if (ticlr_we && wr_data[0])
                ti <= 1'b0;
            else if (tmr_en && at_zero)
                ti <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_regfile.sv ====
`default_nettype none

module csr_regfile
    import csr_map_pkg::*, csr_op_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic [IS_HW_W-1:0] hw_int,
    input  csr_addr_t          rd_addr,
    input  logic               wr_en,
    input  csr_addr_t          wr_addr,
    input  logic [31:0]        wr_data,
    input  logic               entry_en,
    input  ecode_t             entry_ecode,
    input  esubcode_t          entry_esub,
    input  logic [31:0]        entry_era,
    input  logic               entry_badv_en,
    input  logic [31:0]        entry_badv,
    input  logic               ertn_en,
    input  logic [31:0]        tcfg,
    input  logic [31:0]        tval,
    input  logic               ti,
    output logic [31:0]        rd_data,
    output logic               int_req,
    output logic [31:0]        era,
    output logic [31:0]        eentry,
    output logic               tcfg_we,
    output logic               ticlr_we
);

    logic [31:0]              crmd;
    logic [31:0]              prmd;
    logic [31:0]              ecfg;
    logic [IS_SW_W-1:0]       is_sw;
    ecode_t                   estat_ecode;
    esubcode_t                estat_esub;
    logic [31:0]              badv;
    logic [31:EENTRY_ALIGN]   eentry_hi;
    logic [31:0]              save [4];
    logic [31:0]              tid;
    logic [12:0]              is_all;
    logic [31:0]              estat;

    always_comb
    begin
        is_all                   = '0;
        is_all[IS_SW_W-1:0]      = is_sw;
        is_all[IS_SW_W+:IS_HW_W] = hw_int;
        is_all[TI_BIT]           = ti;
    end

    assign estat    = {1'b0, estat_esub, estat_ecode, 3'b000, is_all};
    assign int_req  = |(is_all & ecfg[12:0]) && crmd[CRMD_IE_BIT];
    assign eentry   = {eentry_hi, {EENTRY_ALIGN{1'b0}}};
    assign tcfg_we  = wr_en && (wr_addr == CSR_TCFG);
    assign ticlr_we = wr_en && (wr_addr == CSR_TICLR);

    always_comb
    begin
        case (rd_addr)
            CSR_CRMD:   rd_data = crmd;
            CSR_PRMD:   rd_data = prmd;
            CSR_ECFG:   rd_data = ecfg;
            CSR_ESTAT:  rd_data = estat;
            CSR_ERA:    rd_data = era;
            CSR_BADV:   rd_data = badv;
            CSR_EENTRY: rd_data = eentry;
            CSR_SAVE0:  rd_data = save[0];
            CSR_SAVE1:  rd_data = save[1];
            CSR_SAVE2:  rd_data = save[2];
            CSR_SAVE3:  rd_data = save[3];
            CSR_TID:    rd_data = tid;
            CSR_TCFG:   rd_data = tcfg;
            CSR_TVAL:   rd_data = tval;
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= CRMD_RESET;
            prmd        <= '0;
            ecfg        <= '0;
            is_sw       <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era         <= '0;
            badv        <= '0;
            eentry_hi   <= '0;
            save        <= '{default: '0};
            tid         <= '0;
        end
        else if (entry_en)
        begin
            // save plv and ie, then run kernel with interrupts off
            prmd        <= {29'b0, crmd[2:0]};
            crmd[2:0]   <= 3'b000;
            era         <= entry_era;
            estat_ecode <= entry_ecode;
            estat_esub  <= entry_esub;
            if (entry_badv_en)
                badv <= entry_badv;
        end
        else if (ertn_en)
        begin
            crmd[2:0] <= prmd[2:0];
        end
        else if (wr_en)
        begin
            case (wr_addr)
                CSR_CRMD:   crmd      <= wr_data & CRMD_MASK;
                CSR_PRMD:   prmd      <= wr_data & PRMD_MASK;
                CSR_ECFG:   ecfg      <= wr_data & LIE_MASK;
                CSR_ESTAT:  is_sw     <= wr_data[IS_SW_W-1:0];
                CSR_ERA:    era       <= wr_data;
                CSR_BADV:   badv      <= wr_data;
                CSR_EENTRY: eentry_hi <= wr_data[31:EENTRY_ALIGN];
                CSR_SAVE0:  save[0]   <= wr_data;
                CSR_SAVE1:  save[1]   <= wr_data;
                CSR_SAVE2:  save[2]   <= wr_data;
                CSR_SAVE3:  save[3]   <= wr_data;
                CSR_TID:    tid       <= wr_data;
                default:    ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_ctrl.sv ====
`default_nettype none

module csr_ctrl
    import csr_map_pkg::*, csr_op_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        op_valid,
    input  csr_op_e     op,
    input  csr_arg_u    arg,
    input  logic [31:0] wdata,
    input  logic [31:0] wmask,
    input  logic [31:0] pc,
    input  logic [31:0] badv_in,
    input  logic        int_req,
    input  logic [31:0] era,
    input  logic [31:0] eentry,
    input  logic [31:0] rd_data,
    output csr_addr_t   rd_addr,
    output logic        wr_en,
    output csr_addr_t   wr_addr,
    output logic [31:0] wr_data,
    output logic        entry_en,
    output ecode_t      entry_ecode,
    output esubcode_t   entry_esub,
    output logic [31:0] entry_era,
    output logic        entry_badv_en,
    output logic [31:0] entry_badv,
    output logic        ertn_en,
    output logic [31:0] rdata,
    output logic        flush,
    output logic [31:0] flush_pc
);

    logic        op_go;
    logic        is_rd;
    logic [31:0] merge_mask;
    logic [31:0] last_pc;

    always_comb
    begin
        // a pending interrupt drops the operation
        op_go      = op_valid && !int_req;
        is_rd      = op_go && (op == OP_CSRRD);
        rd_addr    = arg.csr.num;
        wr_addr    = arg.csr.num;
        merge_mask = (op == OP_CSRXCHG) ? wmask : 32'hffff_ffff;
        wr_data    = (rd_data & ~merge_mask) | (wdata & merge_mask);
        wr_en      = op_go && (op == OP_CSRWR || op == OP_CSRXCHG);
        ertn_en    = op_go && (op == OP_ERTN);

        entry_en    = int_req || (op_go && op == OP_EXCP);
        entry_ecode = int_req ? ECODE_INT : arg.excp.ecode;
        entry_esub  = int_req ? '0 : arg.excp.esub;
        entry_era   = op_valid ? pc : last_pc;

        // badv only for address faults
        entry_badv_en = entry_en && !int_req &&
                        (arg.excp.ecode == ECODE_ADE || arg.excp.ecode == ECODE_ALE);
        if (arg.excp.ecode == ECODE_ADE && arg.excp.esub == ESUB_ADEF)
            entry_badv = pc;
        else
            entry_badv = badv_in;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            flush    <= 1'b0;
            flush_pc <= '0;
            rdata    <= '0;
            last_pc  <= '0;
        end
        else
        begin
            flush <= entry_en || ertn_en || wr_en;
            if (op_valid)
                last_pc <= pc;
            if (entry_en)
                flush_pc <= eentry;
            else if (ertn_en)
                flush_pc <= era;
            else if (wr_en)
                flush_pc <= pc + 32'd4;
            // old value for rd, wr and xchg
            if (is_rd || wr_en)
                rdata <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_unit.sv ====
`default_nettype none

module csr_unit
    import csr_map_pkg::*, csr_op_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               op_valid,
    input  csr_op_e            op,
    input  csr_arg_u           arg,
    input  logic [31:0]        wdata,
    input  logic [31:0]        wmask,
    input  logic [31:0]        pc,
    input  logic [31:0]        badv_in,
    input  logic [IS_HW_W-1:0] hw_int,
    output logic [31:0]        rdata,
    output logic               flush,
    output logic [31:0]        flush_pc
);

    csr_addr_t   rd_addr;
    csr_addr_t   wr_addr;
    logic [31:0] rd_data;
    logic [31:0] wr_data;
    logic        wr_en;
    logic        entry_en;
    ecode_t      entry_ecode;
    esubcode_t   entry_esub;
    logic [31:0] entry_era;
    logic        entry_badv_en;
    logic [31:0] entry_badv;
    logic        ertn_en;
    logic        int_req;
    logic [31:0] era;
    logic [31:0] eentry;
    logic        tcfg_we;
    logic        ticlr_we;
    logic [31:0] tcfg;
    logic [31:0] tval;
    logic        ti;

    csr_ctrl ctrl0 (
        .clk           (clk),
        .rstn          (rstn),
        .op_valid      (op_valid),
        .op            (op),
        .arg           (arg),
        .wdata         (wdata),
        .wmask         (wmask),
        .pc            (pc),
        .badv_in       (badv_in),
        .int_req       (int_req),
        .era           (era),
        .eentry        (eentry),
        .rd_data       (rd_data),
        .rd_addr       (rd_addr),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .entry_en      (entry_en),
        .entry_ecode   (entry_ecode),
        .entry_esub    (entry_esub),
        .entry_era     (entry_era),
        .entry_badv_en (entry_badv_en),
        .entry_badv    (entry_badv),
        .ertn_en       (ertn_en),
        .rdata         (rdata),
        .flush         (flush),
        .flush_pc      (flush_pc)
    );

    csr_regfile regs0 (
        .clk           (clk),
        .rstn          (rstn),
        .hw_int        (hw_int),
        .rd_addr       (rd_addr),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .entry_en      (entry_en),
        .entry_ecode   (entry_ecode),
        .entry_esub    (entry_esub),
        .entry_era     (entry_era),
        .entry_badv_en (entry_badv_en),
        .entry_badv    (entry_badv),
        .ertn_en       (ertn_en),
        .tcfg          (tcfg),
        .tval          (tval),
        .ti            (ti),
        .rd_data       (rd_data),
        .int_req       (int_req),
        .era           (era),
        .eentry        (eentry),
        .tcfg_we       (tcfg_we),
        .ticlr_we      (ticlr_we)
    );

    csr_timer timer0 (
        .clk      (clk),
        .rstn     (rstn),
        .tcfg_we  (tcfg_we),
        .ticlr_we (ticlr_we),
        .wr_data  (wr_data),
        .tcfg     (tcfg),
        .tval     (tval),
        .ti       (ti)
    );

endmodule

`default_nettype wire

// ==== sim/csr_unit_asserts.sv ====
`default_nettype none

module csr_unit_asserts
    import csr_map_pkg::*;
(
    input logic        clk,
    input logic        rstn,
    input logic        op_valid,
    input logic        flush,
    input logic [31:0] flush_pc
);

    flush_off_after_reset: assert property (
        @(posedge clk) !rstn |=> !flush
    ) else $error("flush set in the cycle after reset");

    flush_known: assert property (
        @(posedge clk) disable iff (!rstn) !$isunknown(flush)
    ) else $error("flush is unknown after reset release");

    // no op before it, so only an interrupt entry
    irq_flush_aligned: assert property (
        @(posedge clk) disable iff (!rstn)
        (flush && !$past(op_valid)) |-> (flush_pc[EENTRY_ALIGN-1:0] == '0)
    ) else $error("interrupt flush_pc %08h not aligned", flush_pc);

endmodule

bind csr_unit csr_unit_asserts asserts0 (
    .clk      (clk),
    .rstn     (rstn),
    .op_valid (op_valid),
    .flush    (flush),
    .flush_pc (flush_pc)
);

`default_nettype wire

// ==== sim/csr_unit_tb.sv ====
`default_nettype none

module csr_unit_tb
    import csr_map_pkg::*, csr_op_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    localparam csr_addr_t KEPT [15] = '{
        CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG, CSR_TVAL, CSR_TICLR
    };
    localparam csr_addr_t PLAIN [7] = '{
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_ERA, CSR_EENTRY
    };

    logic               clk = 1'b0;
    logic               rstn;
    logic               op_valid;
    csr_op_e            op;
    csr_arg_u           arg;
    logic [31:0]        wdata;
    logic [31:0]        wmask;
    logic [31:0]        pc;
    logic [31:0]        badv_in;
    logic [IS_HW_W-1:0] hw_int;
    logic [31:0]        rdata;
    logic               flush;
    logic [31:0]        flush_pc;

    // shadow csr state by low csr number bits
    logic [31:0] shadow [128];
    logic [31:0] last_pc;
    int          errors;

    logic        chk_now;
    logic        chk_rd_now;
    logic [31:0] exp_rdata_now;
    logic        exp_flush_now;
    logic [31:0] exp_fpc_now;
    logic        chk_q;
    logic        chk_rd_q;
    logic [31:0] exp_rdata_q;
    logic        exp_flush_q;
    logic [31:0] exp_fpc_q;

    csr_unit dut0 (
        .clk      (clk),
        .rstn     (rstn),
        .op_valid (op_valid),
        .op       (op),
        .arg      (arg),
        .wdata    (wdata),
        .wmask    (wmask),
        .pc       (pc),
        .badv_in  (badv_in),
        .hw_int   (hw_int),
        .rdata    (rdata),
        .flush    (flush),
        .flush_pc (flush_pc)
    );

    always #50 clk = ~clk;

    task automatic stop_run();
        errors++;
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s is %08h, expected %08h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s is %0b, expected %0b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ecode(input string name, input ecode_t got, input ecode_t exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s is %02h, expected %02h", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [6:0] slot(input csr_addr_t addr);
        return addr[6:0];
    endfunction

    function automatic logic [31:0] writable_bits(input csr_addr_t addr);
        case (addr)
            CSR_CRMD:   return 32'h0000_01ff;
            CSR_PRMD:   return 32'h0000_0007;
            CSR_ECFG:   return LIE_MASK;
            CSR_ESTAT:  return 32'h0000_0003;
            CSR_EENTRY: return ~((32'd1 << EENTRY_ALIGN) - 32'd1);
            CSR_ERA, CSR_BADV, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG:
                return 32'hffff_ffff;
            default:    return 32'h0;
        endcase
    endfunction

    function automatic void model_entry(input ecode_t code, input esubcode_t sub,
                                        input logic [31:0] at_pc);
        shadow[slot(CSR_PRMD)]             = {29'b0, shadow[slot(CSR_CRMD)][2:0]};
        shadow[slot(CSR_CRMD)][2:0]        = 3'b000;
        shadow[slot(CSR_ERA)]              = at_pc;
        shadow[slot(CSR_ESTAT)][21:16]     = code;
        shadow[slot(CSR_ESTAT)][30:22]     = sub;
    endfunction

    // expected rdata, flush and flush_pc, and the shadow update
    function automatic void predict(
        input  csr_op_e     kind,
        input  csr_arg_u    a,
        input  logic [31:0] wd,
        input  logic [31:0] wm,
        input  logic [31:0] at_pc,
        input  logic [31:0] fault,
        output logic [31:0] e_rdata,
        output logic        e_flush,
        output logic [31:0] e_fpc
    );
        logic [6:0]  i;
        logic [31:0] old;
        logic [31:0] merged;
        logic [31:0] keep;
        i       = slot(a.csr.num);
        old     = shadow[i];
        merged  = (kind == OP_CSRXCHG) ? ((old & ~wm) | (wd & wm)) : wd;
        keep    = writable_bits(a.csr.num);
        e_rdata = old;
        e_flush = 1'b0;
        e_fpc   = 32'h0;
        case (kind)
            OP_CSRWR, OP_CSRXCHG:
            begin
                shadow[i] = (old & ~keep) | (merged & keep);
                e_flush   = 1'b1;
                e_fpc     = at_pc + 32'd4;
            end
            OP_ERTN:
            begin
                shadow[slot(CSR_CRMD)][2:0] = shadow[slot(CSR_PRMD)][2:0];
                e_flush = 1'b1;
                e_fpc   = shadow[slot(CSR_ERA)];
            end
            OP_EXCP:
            begin
                e_flush = 1'b1;
                e_fpc   = shadow[slot(CSR_EENTRY)];
                model_entry(a.excp.ecode, a.excp.esub, at_pc);
                if (a.excp.ecode == ECODE_ADE && a.excp.esub == ESUB_ADEF)
                    shadow[slot(CSR_BADV)] = at_pc;
                else if (a.excp.ecode == ECODE_ADE || a.excp.ecode == ECODE_ALE)
                    shadow[slot(CSR_BADV)] = fault;
            end
            default: ;
        endcase
    endfunction

    // expectations move with the edge that samples the op
    always @(posedge clk)
    begin
        chk_q       <= chk_now;
        chk_rd_q    <= chk_rd_now;
        exp_rdata_q <= exp_rdata_now;
        exp_flush_q <= exp_flush_now;
        exp_fpc_q   <= exp_fpc_now;
    end

    always @(negedge clk)
    begin
        if (chk_q)
        begin
            check_flag("flush", flush, exp_flush_q);
            if (exp_flush_q)
                check_word("flush_pc", flush_pc, exp_fpc_q);
            if (chk_rd_q)
                check_word("rdata", rdata, exp_rdata_q);
        end
    end

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $urandom;
        return {r[31:2], 2'b00};
    endfunction

    task automatic drive_op(input csr_op_e kind, input csr_arg_u a, input logic [31:0] wd,
                            input logic [31:0] wm, input logic [31:0] fault,
                            input logic check_rd);
        logic [31:0] at_pc;
        logic [31:0] e_rdata;
        logic        e_flush;
        logic [31:0] e_fpc;
        at_pc = rand_pc();
        predict(kind, a, wd, wm, at_pc, fault, e_rdata, e_flush, e_fpc);
        op_valid      = 1'b1;
        op            = kind;
        arg           = a;
        wdata         = wd;
        wmask         = wm;
        pc            = at_pc;
        badv_in       = fault;
        last_pc       = at_pc;
        exp_rdata_now = e_rdata;
        exp_flush_now = e_flush;
        exp_fpc_now   = e_fpc;
        chk_rd_now    = check_rd && (kind == OP_CSRRD || kind == OP_CSRWR ||
                                     kind == OP_CSRXCHG);
        chk_now       = 1'b1;
        @(negedge clk);
        op_valid = 1'b0;
        chk_now  = 1'b0;
    endtask

    task automatic access(input csr_op_e kind, input csr_addr_t addr,
                          input logic [31:0] wd, input logic [31:0] wm);
        csr_arg_u a;
        a         = '0;
        a.csr.num = addr;
        drive_op(kind, a, wd, wm, 32'h0, 1'b1);
    endtask

    // for fields the shadow does not follow
    task automatic read_raw(input csr_addr_t addr, output logic [31:0] value);
        csr_arg_u a;
        a         = '0;
        a.csr.num = addr;
        drive_op(OP_CSRRD, a, 32'h0, 32'h0, 32'h0, 1'b0);
        value = rdata;
    endtask

    task automatic raise_excp(input ecode_t code, input esubcode_t sub,
                              input logic [31:0] fault);
        csr_arg_u a;
        a            = '0;
        a.excp.ecode = code;
        a.excp.esub  = sub;
        drive_op(OP_EXCP, a, 32'h0, 32'h0, fault, 1'b0);
    endtask

    task automatic take_entry();
        check_word("flush_pc", flush_pc, shadow[slot(CSR_EENTRY)]);
        model_entry(ECODE_INT, '0, last_pc);
    endtask

    task automatic wait_interrupt(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!flush)
        begin
            n++;
            if (n == WAIT_LIMIT)
            begin
                $display("timed out waiting for the %s interrupt", what);
                stop_run();
            end
            @(negedge clk);
        end
        take_entry();
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            check_flag("flush", flush, 1'b0);
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] word;
        logic [2:0]  b;
        csr_op_e     kind;
        void'($urandom(36230));
        rstn          = 1'b0;
        op_valid      = 1'b0;
        op            = OP_NOP;
        arg           = '0;
        wdata         = '0;
        wmask         = '0;
        pc            = '0;
        badv_in       = '0;
        hw_int        = '0;
        chk_now       = 1'b0;
        chk_rd_now    = 1'b0;
        exp_rdata_now = '0;
        exp_flush_now = 1'b0;
        exp_fpc_now   = '0;
        last_pc       = '0;
        errors        = 0;
        foreach (shadow[k])
            shadow[k] = '0;
        shadow[slot(CSR_CRMD)] = CRMD_RESET;
        repeat (4) @(negedge clk);
        rstn = 1'b1;

        // reset values
        foreach (KEPT[k])
            access(OP_CSRRD, KEPT[k], 32'h0, 32'h0);

        // random access on plain csrs
        for (int i = 0; i < 60; i++)
        begin
            r = $urandom;
            if (r[1:0] == 2'd0)
                kind = OP_CSRRD;
            else if (r[1:0] == 2'd1)
                kind = OP_CSRWR;
            else
                kind = OP_CSRXCHG;
            access(kind, PLAIN[int'(r[15:8]) % 7], $urandom, $urandom);
        end
        foreach (PLAIN[k])
            access(OP_CSRRD, PLAIN[k], 32'h0, 32'h0);

        // syscall from plv 3
        access(OP_CSRXCHG, CSR_CRMD, 32'h3, 32'h3);
        raise_excp(ECODE_SYS, 9'h001, 32'h0);
        read_raw(CSR_ESTAT, word);
        check_ecode("estat.ecode", word[21:16], ECODE_SYS);
        check_word("estat.esubcode", {23'b0, word[30:22]}, {23'b0, 9'h001});
        access(OP_CSRRD, CSR_ERA, 32'h0, 32'h0);
        access(OP_CSRRD, CSR_PRMD, 32'h0, 32'h0);
        access(OP_CSRRD, CSR_CRMD, 32'h0, 32'h0);

        // fetch address error, badv takes pc
        access(OP_CSRXCHG, CSR_CRMD, 32'h1, 32'h3);
        raise_excp(ECODE_ADE, ESUB_ADEF, $urandom);
        read_raw(CSR_ESTAT, word);
        check_ecode("estat.ecode", word[21:16], ECODE_ADE);
        check_word("estat.esubcode", {23'b0, word[30:22]}, {23'b0, ESUB_ADEF});
        access(OP_CSRRD, CSR_BADV, 32'h0, 32'h0);
        access(OP_CSRRD, CSR_ERA, 32'h0, 32'h0);
        access(OP_CSRRD, CSR_PRMD, 32'h0, 32'h0);
        raise_excp(ECODE_ALE, '0, $urandom);
        access(OP_CSRRD, CSR_BADV, 32'h0, 32'h0);

        // return into plv 3
        access(OP_CSRWR, CSR_PRMD, 32'h3, 32'h0);
        drive_op(OP_ERTN, '0, 32'h0, 32'h0, 32'h0, 1'b0);
        access(OP_CSRRD, CSR_CRMD, 32'h0, 32'h0);
        access(OP_CSRXCHG, CSR_CRMD, 32'h0, 32'h7);

        // one-shot timer, initial value 16
        access(OP_CSRWR, CSR_EENTRY, $urandom, 32'h0);
        access(OP_CSRWR, CSR_ECFG, 32'h1 << TI_BIT, 32'h0);
        access(OP_CSRWR, CSR_TCFG, 32'h0000_0011, 32'h0);
        access(OP_CSRXCHG, CSR_CRMD, 32'h4, 32'h4);
        wait_interrupt("one-shot timer");
        read_raw(CSR_ESTAT, word);
        check_ecode("estat.ecode", word[21:16], ECODE_INT);
        check_word("estat.is timer", word & (32'h1 << TI_BIT), 32'h1 << TI_BIT);
        access(OP_CSRRD, CSR_ERA, 32'h0, 32'h0);
        access(OP_CSRRD, CSR_PRMD, 32'h0, 32'h0);
        access(OP_CSRWR, CSR_TICLR, 32'h1, 32'h0);
        read_raw(CSR_ESTAT, word);
        check_word("estat.is timer", word & (32'h1 << TI_BIT), 32'h0);

        // periodic timer fires again once ie is back
        access(OP_CSRWR, CSR_TCFG, 32'h0000_0013, 32'h0);
        access(OP_CSRXCHG, CSR_CRMD, 32'h4, 32'h4);
        wait_interrupt("first periodic timer");
        access(OP_CSRWR, CSR_TICLR, 32'h1, 32'h0);
        access(OP_CSRXCHG, CSR_CRMD, 32'h4, 32'h4);
        wait_interrupt("second periodic timer");
        access(OP_CSRWR, CSR_TCFG, 32'h0, 32'h0);
        access(OP_CSRWR, CSR_TICLR, 32'h1, 32'h0);

        // breakpoint leaves a non-int ecode behind
        raise_excp(ECODE_BRK, '0, 32'h0);

        // hardware line, gated by lie and ie
        r = $urandom;
        b = r[2:0];
        access(OP_CSRWR, CSR_ECFG, 32'h0, 32'h0);
        hw_int = 8'h01 << b;
        expect_idle(5);
        access(OP_CSRXCHG, CSR_CRMD, 32'h4, 32'h4);
        expect_idle(5);
        access(OP_CSRXCHG, CSR_CRMD, 32'h0, 32'h4);
        access(OP_CSRWR, CSR_ECFG, 32'h1 << (IS_SW_W + b), 32'h0);
        expect_idle(5);
        access(OP_CSRXCHG, CSR_CRMD, 32'h4, 32'h4);
        @(negedge clk);
        check_flag("flush", flush, 1'b1);
        take_entry();
        hw_int = '0;
        read_raw(CSR_ESTAT, word);
        check_ecode("estat.ecode", word[21:16], ECODE_INT);
        access(OP_CSRRD, CSR_CRMD, 32'h0, 32'h0);

        repeat (2) @(negedge clk);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/csr_map_pkg.sv
design/csr_op_pkg.sv
design/csr_timer.sv
design/csr_regfile.sv
design/csr_ctrl.sv
design/csr_unit.sv
sim/csr_unit_asserts.sv
sim/csr_unit_tb.sv

// ==== Makefile ====
TOP = csr_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f \
		-Mdir obj_dir -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
